// File: common/sine_quarter.hex
// quarter-wave sine, one signed 16-bit word per line, entry i = sin(i * pi / 64)
0000
0648
0C8C
12C8
18F9
1F1A
2528
2B1F
30FB
36BA
3C56
41CE
471C
4C3F
5133
55F5
5A82
5ED7
62F1
66CF
6A6D
6DC9
70E2
73B5
7641
7884
7A7C
7C29
7D89
7E9C
7F61
7FD8

// File: list.f
common/fm_pkg.sv
rtl/slot_sequencer.sv
rtl/param_regs.sv
operator/fm_operator.sv
mod_matrix/mod_matrix.sv
rtl/fm_voice_engine.sv
bench/fm_assertions.sv
bench/fm_checker.sv
bench/tb_fm_voice_engine.sv

// File: Bender.yml
package:
  name: fm_voice_engine

sources:
  - common/fm_pkg.sv
  - rtl/slot_sequencer.sv
  - rtl/param_regs.sv
  - operator/fm_operator.sv
  - mod_matrix/mod_matrix.sv
  - rtl/fm_voice_engine.sv
  - target: test
    files:
      - bench/fm_assertions.sv
      - bench/fm_checker.sv
      - bench/tb_fm_voice_engine.sv

// File: bench/tb_fm_voice_engine.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fm_voice_engine import fm_pkg::*; ();

    logic                     sCLK_XVXENVS;
    logic                     arst_n;
    logic                     run;
    logic                     param_wr;
    param_word_t              param_data;
    logic                     sample_valid;
    logic [SLOT_W-1:0]        sample_slot;
    logic signed [SINE_W-1:0] sample;
    logic [31:0]              samples_seen;
    logic [31:0]              value_errors;
    logic [31:0]              slot_errors;
    logic [31:0]              other_errors;

    logic        row_run [$];  // stimulus table, one entry per row
    logic        row_wr [$];
    param_word_t row_data [$];
    int          row_hold [$];
    int          expected_samples = 0;
    int          timeout_errors = 0;
    int          assert_errors;
    logic [31:0] rng;

    fm_voice_engine fm_voice_engine_i (.*);

    fm_checker fm_checker_i (.*);

    function automatic logic [31:0] next_random(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic param_word_t mat_word(input logic [1:0] dst, input logic [1:0] src,
                                             input logic [7:0] coef);
        param_word_t w;
        w = '0;
        w.mat.dst = dst;
        w.mat.src = src;
        w.mat.coef = coef;
        return w;
    endfunction

    function automatic param_word_t inc_word(input logic [1:0] osc, input logic [12:0] inc);
        param_word_t w;
        w.inc.is_inc = 1'b1;
        w.inc.osc = osc;
        w.inc.inc = inc;
        return w;
    endfunction

    task automatic add_row(input logic r, input logic wr, input param_word_t d, input int hold);
        row_run.push_back(r);
        row_wr.push_back(wr);
        row_data.push_back(d);
        row_hold.push_back(hold);
        if (r)
            expected_samples += hold;  // one sample per run cycle
    endtask

    initial begin
        sCLK_XVXENVS = 1'b0;
        forever #10 sCLK_XVXENVS = ~sCLK_XVXENVS;
    end

    initial begin
        int wait_cycles;
        run = 1'b0;
        param_wr = 1'b0;
        param_data = '0;
        arst_n = 1'b0;
        rng = 32'd51824;
        add_row(1, 0, '0, 32);  // zero parameters, silent rounds
        add_row(0, 0, '0, 4);
        add_row(0, 1, inc_word(0, 13'h0100), 1);
        add_row(0, 1, inc_word(1, 13'h0233), 1);
        add_row(0, 1, inc_word(2, 13'h0400), 1);
        add_row(0, 1, inc_word(3, 13'h0011), 1);
        add_row(1, 0, '0, 48);
        add_row(0, 1, mat_word(1, 0, 8'h40), 1);  // osc 0 modulates osc 1
        add_row(1, 0, '0, 48);
        add_row(0, 1, mat_word(2, 2, 8'h60), 1);  // feedback on osc 2
        add_row(1, 0, '0, 48);
        for (int i = 0; i < 12; i++) begin
            rng = next_random(rng);
            add_row(1, 1, param_word_t'(rng[31:16]), 1);
            rng = next_random(rng);
            add_row(1, 0, '0, 8 + int'(rng[20:16]));
            if (i % 3 == 2)
                add_row(0, 0, '0, 7);  // pause mid round
        end
        add_row(0, 0, '0, 1);
        repeat (5) @(posedge sCLK_XVXENVS);
        arst_n <= 1'b1;
        for (int i = 0; i < row_run.size(); i++) begin
            @(posedge sCLK_XVXENVS);
            run <= row_run[i];
            param_wr <= row_wr[i];
            param_data <= row_data[i];
            repeat (row_hold[i] - 1) @(posedge sCLK_XVXENVS);
        end
        wait_cycles = 0;
        while (samples_seen != expected_samples && wait_cycles < 2000) begin
            @(negedge sCLK_XVXENVS);
            wait_cycles++;
        end
        if (samples_seen != expected_samples) begin
            $display("timed out with %0d of %0d samples received", samples_seen,
                     expected_samples);
            timeout_errors = 1;
        end
        assert_errors = fm_voice_engine_i.slot_sequencer_i.fm_assertions_i.fail_count;
        $display("errors: value %0d, slot %0d, other %0d, assertion %0d, timeout %0d",
                 value_errors, slot_errors, other_errors, assert_errors, timeout_errors);
        if (value_errors + slot_errors + other_errors + assert_errors + timeout_errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/fm_checker.sv
`timescale 1ns/1ps
`default_nettype none

module fm_checker import fm_pkg::*; (
    input  wire                     sCLK_XVXENVS,
    input  wire                     arst_n,
    input  wire                     run,
    input  wire                     param_wr,
    input  wire [15:0]              param_data,
    input  wire                     sample_valid,
    input  wire [SLOT_W-1:0]        sample_slot,
    input  wire signed [SINE_W-1:0] sample,
    output logic [31:0]             samples_seen,
    output logic [31:0]             value_errors,
    output logic [31:0]             slot_errors,
    output logic [31:0]             other_errors
);

    logic signed [15:0] tab [32];
    logic [15:0]        ph [16];
    logic signed [11:0] mstore [16];  // indexed {voice, dst}
    logic signed [31:0] acc [4];
    logic signed [7:0]  coef [4][4];  // [dst][src]
    logic [12:0]        inc [4];
    logic               srv_valid;    // mirror of sh_osc
    logic               srv_d1;
    logic               srv_d2;       // sh_osc two clocks back
    logic [3:0]         srv_slot;
    logic [3:0]         srv_next;
    logic [3:0]         exp_slot [$];
    logic signed [15:0] exp_val [$];

    initial $readmemh("common/sine_quarter.hex", tab);

    // full wave built quadrant by quadrant from the quarter table
    function automatic logic signed [15:0] sine_of(input logic [15:0] p);
        logic [4:0] idx;
        idx = p[13:9];
        case (p[15:14])
            2'd0:    return tab[idx];
            2'd1:    return tab[5'd31 - idx];
            2'd2:    return -tab[idx];
            default: return -tab[5'd31 - idx];
        endcase
    endfunction

    always @(posedge sCLK_XVXENVS or negedge arst_n) begin : model
        logic [15:0]        lk;
        logic signed [31:0] tot;
        logic [3:0]         es;
        logic signed [15:0] ev;
        if (!arst_n) begin
            for (int i = 0; i < 16; i++) begin
                ph[i] = '0;
                mstore[i] = '0;
            end
            for (int d = 0; d < 4; d++) begin
                acc[d] = '0;
                inc[d] = '0;
                for (int s = 0; s < 4; s++)
                    coef[d][s] = '0;
            end
            srv_valid = 1'b0;
            srv_d1 = 1'b0;
            srv_d2 = 1'b0;
            srv_slot = '0;
            srv_next = '0;
            samples_seen = 0;
            value_errors = 0;
            slot_errors = 0;
            other_errors = 0;
        end else begin
            if (srv_valid) begin  // reads the store before this clock's write
                lk = ph[srv_slot] + inc[srv_slot[1:0]] + {mstore[srv_slot], 4'b0000};
                ph[srv_slot] = ph[srv_slot] + inc[srv_slot[1:0]];
                exp_slot.push_back(srv_slot);
                exp_val.push_back(sine_of(lk));
            end
            if (sample_valid !== srv_d2) begin
                $display("** Error sample_valid: got %h expected %h", sample_valid, srv_d2);
                other_errors++;
            end
            if (sample_valid && exp_slot.size() == 0) begin
                $display("sample_valid at %0t with no slot in flight", $time);
                other_errors++;
            end else if (sample_valid) begin
                es = exp_slot.pop_front();
                ev = exp_val.pop_front();
                samples_seen++;
                if (sample_slot !== es) begin
                    $display("** Error sample_slot: got %h expected %h", sample_slot, es);
                    slot_errors++;
                end
                if (sample !== ev) begin
                    $display("** Error sample: got %h expected %h (slot %h)", sample, ev, es);
                    value_errors++;
                end
                for (int d = 0; d < 4; d++) begin
                    tot = acc[d] + ev * coef[d][es[1:0]];
                    acc[d] = (es[1:0] == 2'd3) ? 32'sd0 : tot;
                    if (es[1:0] == 2'd3)
                        mstore[{es[3:2], d[1:0]}] = 12'(tot >>> 10);  // close the voice frame
                end
            end
            if (param_wr && param_data[15])
                inc[param_data[14:13]] = param_data[12:0];
            else if (param_wr)
                coef[param_data[14:13]][param_data[12:11]] = param_data[7:0];
            srv_d2 = srv_d1;
            srv_d1 = srv_valid;
            srv_valid = run;
            if (run) begin
                srv_slot = srv_next;
                srv_next = srv_next + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/fm_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module fm_assertions import fm_pkg::*; (
    input wire              sCLK_XVXENVS,
    input wire              arst_n,
    input wire              run,
    input wire [SLOT_W-1:0] slot,
    input wire              sh_osc,
    input wire              sh_voice
);

    int fail_count = 0;  // failed assertions so far

    // sh_voice only on a served last oscillator
    voice_in_osc: assert property (@(posedge sCLK_XVXENVS) disable iff (!arst_n)
        sh_voice |-> (sh_osc && slot[OSC_W-1:0] == OSC_W'(V_OSC - 1)))
        else begin
            $error("sh_voice raised off the last oscillator or without sh_osc");
            fail_count++;
        end

    // one step at a time and only after a run cycle
    slot_step: assert property (@(posedge sCLK_XVXENVS) disable iff (!arst_n)
        (slot != $past(slot)) |-> ($past(run) && slot == $past(slot) + 1'b1))
        else begin
            $error("slot moved without run or by more than one");
            fail_count++;
        end

    voice_marked: assert property (@(posedge sCLK_XVXENVS) disable iff (!arst_n)
        (sh_osc && slot[OSC_W-1:0] == OSC_W'(V_OSC - 1)) |-> sh_voice)
        else begin
            $error("last oscillator of a voice served without sh_voice");
            fail_count++;
        end

endmodule

bind slot_sequencer fm_assertions fm_assertions_i (.*);

`default_nettype wire

// File: rtl/fm_voice_engine.sv
`timescale 1ns/1ps
`default_nettype none

module fm_voice_engine import fm_pkg::*; (
    input  wire                      sCLK_XVXENVS,
    input  wire                      arst_n,
    input  wire                      run,
    input  wire                      param_wr,
    input  wire param_word_t         param_data,
    output logic                     sample_valid,
    output logic [SLOT_W-1:0]        sample_slot,
    output logic signed [SINE_W-1:0] sample
);

    logic [SLOT_W-1:0]         slot;
    logic                      sh_osc;
    logic signed [COEF_W-1:0]  coef_mat [V_OSC][V_OSC];
    logic [INC_W-1:0]          inc_tab  [V_OSC];
    logic signed [MOD_W-1:0]   modulation;

    slot_sequencer slot_sequencer_i (
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .arst_n       (arst_n),
        .run          (run),
        .slot         (slot),
        .sh_osc       (sh_osc),
        .sh_voice     ()  // frame end comes from sine_slot downstream
    );

    param_regs param_regs_i (
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .arst_n       (arst_n),
        .param_wr     (param_wr),
        .param_data   (param_data),
        .coef_mat     (coef_mat),
        .inc_tab      (inc_tab)
    );

    fm_operator fm_operator_i (
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .arst_n       (arst_n),
        .slot         (slot),
        .sh_osc       (sh_osc),
        .inc_tab      (inc_tab),
        .modulation   (modulation),
        .sine_out     (sample),  // samples leave 2 clocks after sh_osc
        .sine_slot    (sample_slot),
        .sine_valid   (sample_valid)
    );

    mod_matrix mod_matrix_i (
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .arst_n       (arst_n),
        .sine_out     (sample),
        .sine_slot    (sample_slot),
        .sine_valid   (sample_valid),
        .coef_mat     (coef_mat),
        .slot         (slot),
        .modulation   (modulation)
    );

endmodule

`default_nettype wire

// File: mod_matrix/mod_matrix.sv
`timescale 1ns/1ps
`default_nettype none

module mod_matrix import fm_pkg::*; (
    input  wire                      sCLK_XVXENVS,
    input  wire                      arst_n,
    input  wire signed [SINE_W-1:0]  sine_out,
    input  wire [SLOT_W-1:0]         sine_slot,
    input  wire                      sine_valid,
    input  wire signed [COEF_W-1:0]  coef_mat [V_OSC][V_OSC],
    input  wire [SLOT_W-1:0]         slot,
    output logic signed [MOD_W-1:0]  modulation
);

    logic signed [SUM_W-1:0]           sum   [V_OSC];  // one per destination
    logic signed [MOD_W-1:0]           store [VOICES][V_OSC];
    logic signed [SINE_W+COEF_W-1:0]   prod  [V_OSC];
    logic signed [SUM_W-1:0]           total [V_OSC];

    logic [OSC_W-1:0]   src;
    logic [VOICE_W-1:0] src_voice;
    logic               frame_end;

    assign src       = sine_slot[OSC_W-1:0];
    assign src_voice = sine_slot[SLOT_W-1:OSC_W];
    assign frame_end = (src == OSC_W'(V_OSC - 1));  // last oscillator of the voice

    // weighted contribution of this sample to every destination
    always_comb begin
        for (int d = 0; d < V_OSC; d++) begin
            prod[d]  = sine_out * coef_mat[d][src];
            total[d] = sum[d] + prod[d];  // sign extends the product
        end
    end

    always_ff @(posedge sCLK_XVXENVS or negedge arst_n) begin
        if (!arst_n) begin
            for (int d = 0; d < V_OSC; d++) begin
                sum[d] <= '0;
            end
            for (int v = 0; v < VOICES; v++) begin
                for (int d = 0; d < V_OSC; d++) begin
                    store[v][d] <= '0;
                end
            end
        end else if (sine_valid) begin
            for (int d = 0; d < V_OSC; d++) begin
                if (frame_end) begin
                    store[src_voice][d] <= MOD_W'(total[d] >>> MOD_SHIFT);
                    sum[d]              <= '0;  // fresh frame for the next voice
                end else begin
                    sum[d] <= total[d];
                end
            end
        end
    end

    // A voice's store entries are written two clocks after its last
    // slot and read again a full round later, so each slot sees the
    // modulation built from the previous round.
    assign modulation = store[slot[SLOT_W-1:OSC_W]][slot[OSC_W-1:0]];

endmodule

`default_nettype wire

// File: operator/fm_operator.sv
`timescale 1ns/1ps
`default_nettype none

module fm_operator import fm_pkg::*; (
    input  wire                      sCLK_XVXENVS,
    input  wire                      arst_n,
    input  wire [SLOT_W-1:0]         slot,
    input  wire                      sh_osc,
    input  wire [INC_W-1:0]          inc_tab [V_OSC],
    input  wire signed [MOD_W-1:0]   modulation,
    output logic signed [SINE_W-1:0] sine_out,
    output logic [SLOT_W-1:0]        sine_slot,
    output logic                     sine_valid
);

    logic signed [SINE_W-1:0] quarter_tab [2**TAB_AW];
    logic [PHASE_W-1:0]       phase [SLOTS];  // one accumulator per slot

    logic [PHASE_W-1:0] phase_next;
    logic [PHASE_W-1:0] mod_ph;
    logic [PHASE_W-1:0] lk_phase;  // stage 1 lookup phase
    logic [SLOT_W-1:0]  s1_slot;
    logic               s1_valid;
    logic [TAB_AW-1:0]  tab_addr;
    logic               mirror;
    logic               neg;

    initial $readmemh("common/sine_quarter.hex", quarter_tab);

    assign phase_next = phase[slot] + {{(PHASE_W - INC_W){1'b0}}, inc_tab[slot[OSC_W-1:0]]};
    assign mod_ph     = {modulation, {MOD_LSL{1'b0}}};  // 12 + 4 bits

    // stage 1, advance phase and apply modulation
    always_ff @(posedge sCLK_XVXENVS or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < SLOTS; i++) begin
                phase[i] <= '0;
            end
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= sh_osc;
            if (sh_osc) begin
                phase[slot] <= phase_next;  // modulation is not fed back
            end
        end
    end

    always_ff @(posedge sCLK_XVXENVS) begin
        lk_phase <= phase_next + mod_ph;
        s1_slot  <= slot;
    end

    // top 7 phase bits pick quadrant and table entry
    assign neg      = lk_phase[PHASE_W-1];
    assign mirror   = lk_phase[PHASE_W-2];
    assign tab_addr = mirror ? ~lk_phase[PHASE_W-3 -: TAB_AW] : lk_phase[PHASE_W-3 -: TAB_AW];

    // stage 2, table lookup
    always_ff @(posedge sCLK_XVXENVS or negedge arst_n) begin
        if (!arst_n) begin
            sine_valid <= 1'b0;
        end else begin
            sine_valid <= s1_valid;
        end
    end

    always_ff @(posedge sCLK_XVXENVS) begin
        sine_out  <= neg ? -quarter_tab[tab_addr] : quarter_tab[tab_addr];
        sine_slot <= s1_slot;
    end

endmodule

`default_nettype wire

// File: rtl/param_regs.sv
`timescale 1ns/1ps
`default_nettype none

module param_regs import fm_pkg::*; (
    input  wire                      sCLK_XVXENVS,
    input  wire                      arst_n,
    input  wire                      param_wr,
    input  wire param_word_t         param_data,
    output logic signed [COEF_W-1:0] coef_mat [V_OSC][V_OSC],
    output logic [INC_W-1:0]         inc_tab  [V_OSC]
);

    logic is_inc;

    assign is_inc = param_data.inc.is_inc;  // same bit in both views

    // one entry per write pulse, visible from the next clock
    always_ff @(posedge sCLK_XVXENVS or negedge arst_n) begin
        if (!arst_n) begin
            for (int d = 0; d < V_OSC; d++) begin
                inc_tab[d] <= '0;
                for (int s = 0; s < V_OSC; s++) begin
                    coef_mat[d][s] <= '0;
                end
            end
        end else if (param_wr) begin
            if (is_inc) begin
                inc_tab[param_data.inc.osc] <= param_data.inc.inc;
            end else begin
                // diagonal entries act as feedback
                coef_mat[param_data.mat.dst][param_data.mat.src] <= param_data.mat.coef;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/slot_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module slot_sequencer import fm_pkg::*; (
    input  wire               sCLK_XVXENVS,
    input  wire               arst_n,
    input  wire               run,
    output logic [SLOT_W-1:0] slot,
    output logic              sh_osc,
    output logic              sh_voice
);

    logic [SLOT_W-1:0] next_slot;  // slot served on the next run cycle
    logic              last_osc;

    assign last_osc = (next_slot[OSC_W-1:0] == OSC_W'(V_OSC - 1));

    // slot and strobes are registered together so they line up
    always_ff @(posedge sCLK_XVXENVS or negedge arst_n) begin
        if (!arst_n) begin
            slot      <= '0;
            next_slot <= '0;
            sh_osc    <= 1'b0;
            sh_voice  <= 1'b0;
        end else begin
            sh_osc   <= run;
            sh_voice <= run && last_osc;  // end of a voice frame
            if (run) begin
                slot      <= next_slot;
                next_slot <= next_slot + 1'b1;  // wraps after slot 15
            end
        end
    end

    // Holding run low leaves slot on the last served value, so the
    // round picks up at next_slot once run returns.

endmodule

`default_nettype wire

// File: common/fm_pkg.sv
`default_nettype none

package fm_pkg;

    // voice and slot geometry
    localparam int VOICES  = 4;
    localparam int V_OSC   = 4;               // oscillators per voice
    localparam int SLOTS   = VOICES * V_OSC;  // one slot per clock
    localparam int SLOT_W  = 4;               // {voice, osc}
    localparam int OSC_W   = 2;
    localparam int VOICE_W = 2;

    // datapath widths
    localparam int SINE_W  = 16;  // signed sample
    localparam int COEF_W  = 8;   // signed matrix entry
    localparam int PHASE_W = 16;
    localparam int INC_W   = 13;  // unsigned increment
    localparam int SUM_W   = 32;  // matrix accumulator
    localparam int MOD_W   = 12;  // signed modulation
    localparam int TAB_AW  = 5;   // quarter-wave table address

    localparam int MOD_SHIFT = 10;  // sum to modulation scaling
    localparam int MOD_LSL   = 4;   // modulation to phase scaling

    // matrix view, coef lands in coef_mat[dst][src]
    typedef struct packed {
        logic                     is_inc;  // 0 here
        logic [OSC_W-1:0]         dst;
        logic [OSC_W-1:0]         src;
        logic [2:0]               rsvd;
        logic signed [COEF_W-1:0] coef;
    } param_mat_t;

    typedef struct packed {
        logic             is_inc;  // 1 here
        logic [OSC_W-1:0] osc;
        logic [INC_W-1:0] inc;
    } param_inc_t;

    typedef union packed {
        param_mat_t mat;
        param_inc_t inc;
    } param_word_t;

endpackage

`default_nettype wire
